// File: verilog/uart_pkg.sv
//////////////////////////////
// UART peripheral definitions
// Widths of the data paths, the register
// index map and the receiver FSM states
//////////////////////////////

package uart_pkg;

    //////////////////////////////
    // Data path widths
    //////////////////////////////

    // One character, also one FIFO entry
    typedef logic [8-1:0]  dat_t;
    // Baud divider or sample offset, bit period is value plus one
    typedef logic [16-1:0] bdr_t;
    // FIFO fill count or interrupt limit
    typedef logic [8-1:0]  cnt_t;
    // Bus data word
    typedef logic [32-1:0] sys_t;
    // Register index
    typedef logic [4-1:0]  adr_t;

    //////////////////////////////
    // Register map
    //////////////////////////////

    // TX side
    localparam adr_t REG_TX_DAT = 4'd0;
    localparam adr_t REG_TX_CNT = 4'd1;
    localparam adr_t REG_TX_BDR = 4'd2;
    localparam adr_t REG_TX_IRQ = 4'd3;
    // RX side
    localparam adr_t REG_RX_DAT = 4'd4;
    localparam adr_t REG_RX_CNT = 4'd5;
    localparam adr_t REG_RX_BDR = 4'd6;
    localparam adr_t REG_RX_SMP = 4'd7;
    localparam adr_t REG_RX_IRQ = 4'd8;

    // Receiver FSM
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

endpackage

// File: verilog/uart_bus_if.sv
//////////////////////////////
// UART register bus
// Plain strobes, no wait states, read
// data valid in the access cycle
//////////////////////////////

`timescale 1ns/1ps

interface uart_bus_if;

    // Transfer valid, qualifies both strobes
    logic             trn;
    // Write and read strobes
    logic             wen;
    logic             ren;
    // Register index and data
    uart_pkg::adr_t   adr;
    uart_pkg::sys_t   wdt;
    uart_pkg::sys_t   rdt;

    // Bus manager side
    modport mgr (output trn, wen, ren, adr, wdt, input rdt);

    // Register block side
    modport sub (input trn, wen, ren, adr, wdt, output rdt);

endinterface

// File: verilog/uart_fifo.sv
//////////////////////////////
// UART synchronous FIFO
// Circular buffer with fill count,
// push when full and pop when empty ignored
//////////////////////////////

`timescale 1ns/1ps

module uart_fifo #(
    parameter int unsigned FIFO_SIZ = 16
)(
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  uart_pkg::dat_t wdat,
    input  logic           pop,
    output uart_pkg::dat_t rdat,
    output uart_pkg::cnt_t cnt
);

    // Pointer width, at least one bit
    localparam int unsigned FIFO_ADR = (FIFO_SIZ > 1) ? $clog2(FIFO_SIZ) : 1;

    typedef logic [FIFO_ADR-1:0] ptr_t;

    uart_pkg::dat_t mem [FIFO_SIZ];
    ptr_t           wr_ptr;
    ptr_t           rd_ptr;
    logic           full;
    logic           empty;
    logic           do_push;
    logic           do_pop;

    // Status from the fill count
    assign empty = (cnt == '0);
    assign full  = (cnt == uart_pkg::cnt_t'(FIFO_SIZ));

    // Qualified transfers
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // Storage array
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wdat;
    end

    // Head of queue
    assign rdat = mem[rd_ptr];

    // Pointers wrap at the last entry, depth need not be a power of two
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == ptr_t'(FIFO_SIZ-1)) ? '0 : wr_ptr + ptr_t'(1);
            if (do_pop)
                rd_ptr <= (rd_ptr == ptr_t'(FIFO_SIZ-1)) ? '0 : rd_ptr + ptr_t'(1);
        end
    end

    // Fill counter, unchanged on simultaneous push and pop
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            cnt <= '0;
        else if (do_push && !do_pop)
            cnt <= cnt + uart_pkg::cnt_t'(1);
        else if (do_pop && !do_push)
            cnt <= cnt - uart_pkg::cnt_t'(1);
    end

endmodule

// File: verilog/uart_tx.sv
//////////////////////////////
// UART transmitter
// Pulls bytes from the TX FIFO and
// shifts out 8N1 frames, LSB first
//////////////////////////////

`timescale 1ns/1ps

module uart_tx (
    input  logic           clk,
    input  logic           rst_n,
    input  uart_pkg::bdr_t bdr,
    input  uart_pkg::cnt_t fifo_cnt,
    input  uart_pkg::dat_t fifo_dat,
    output logic           fifo_pop,
    output logic           txd
);

    // Frame in progress
    logic           busy;
    // Stop, data and start bits, bit 0 on the line
    logic [10-1:0]  shf;
    // Cycles left in the current bit
    uart_pkg::bdr_t bcnt;
    // Bits left after the current one
    logic [4-1:0]   bidx;

    // Take a byte whenever idle and data waits
    assign fifo_pop = ~busy & (fifo_cnt != '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            // All ones keeps the line idle high
            shf  <= '1;
            bcnt <= '0;
            bidx <= '0;
        end
        else if (fifo_pop)
        begin
            // Load frame, start bit goes out next cycle
            busy <= 1'b1;
            shf  <= {1'b1, fifo_dat, 1'b0};
            bcnt <= bdr;
            bidx <= 4'd9;
        end
        else if (busy)
        begin
            if (bcnt != '0)
                bcnt <= bcnt - uart_pkg::bdr_t'(1);
            else
            begin
                // Bit boundary
                bcnt <= bdr;
                if (bidx == '0)
                    busy <= 1'b0;
                else
                begin
                    // Ones fill in behind, line ends high
                    shf  <= {1'b1, shf[9:1]};
                    bidx <= bidx - 4'd1;
                end
            end
        end
    end

    assign txd = shf[0];

endmodule

// File: verilog/uart_rx.sv
//////////////////////////////
// UART receiver
// Synchronizes the line, detects the start
// edge, samples 8N1 frames at a programmable
// offset and pushes valid bytes to the RX FIFO
//////////////////////////////

`timescale 1ns/1ps

module uart_rx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rxd,
    input  uart_pkg::bdr_t bdr,
    input  uart_pkg::bdr_t smp,
    output logic           fifo_push,
    output uart_pkg::dat_t fifo_dat
);

    // Two synchronizer stages plus one for edge detection
    logic [3-1:0]        rxd_sync;
    logic                rxd_s;
    logic                rxd_fall;
    uart_pkg::rx_state_t state;
    // Cycles into the current bit
    uart_pkg::bdr_t      bcnt;
    // Data bit index
    logic [3-1:0]        bidx;
    uart_pkg::dat_t      shf;
    logic                smp_hit;
    logic                bit_end;

    //////////////////////////////
    // Line input
    //////////////////////////////

    // Idle line is high
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rxd_sync <= '1;
        else
            rxd_sync <= {rxd_sync[1:0], rxd};
    end

    assign rxd_s    = rxd_sync[1];
    // High to low after the synchronizer
    assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

    //////////////////////////////
    // Bit timing and FSM
    //////////////////////////////

    assign smp_hit = (bcnt == smp);
    assign bit_end = (bcnt == bdr);

    // Counter held at zero while idle, restarts at each bit boundary
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            bcnt <= '0;
        else if (state == uart_pkg::IDLE || bit_end)
            bcnt <= '0;
        else
            bcnt <= bcnt + uart_pkg::bdr_t'(1);
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= uart_pkg::IDLE;
            bidx  <= '0;
        end
        else
        begin
            case (state)
                uart_pkg::IDLE:
                begin
                    if (rxd_fall)
                        state <= uart_pkg::START;
                end
                uart_pkg::START:
                begin
                    // Glitch, start bit gone at the sample point
                    if (smp_hit && rxd_s)
                        state <= uart_pkg::IDLE;
                    else if (bit_end)
                    begin
                        state <= uart_pkg::DATA;
                        bidx  <= '0;
                    end
                end
                uart_pkg::DATA:
                begin
                    if (bit_end)
                    begin
                        if (bidx == 3'd7)
                            state <= uart_pkg::STOP;
                        else
                            bidx <= bidx + 3'd1;
                    end
                end
                uart_pkg::STOP:
                begin
                    // Back to idle early, ready for the next start edge
                    if (smp_hit)
                        state <= uart_pkg::IDLE;
                end
                default:
                begin
                    state <= uart_pkg::IDLE;
                end
            endcase
        end
    end

    // Data shifter, LSB arrives first
    always_ff @(posedge clk)
    begin
        if (state == uart_pkg::DATA && smp_hit)
            shf <= {rxd_s, shf[7:1]};
    end

    // Push only with a high stop bit
    assign fifo_push = (state == uart_pkg::STOP) & smp_hit & rxd_s;
    assign fifo_dat  = shf;

endmodule

// File: verilog/uart_regs.sv
//////////////////////////////
// UART register bank
// Bus decode, configuration registers,
// FIFO push and pop, read multiplexer
// and fill level interrupts
//////////////////////////////

`timescale 1ns/1ps

module uart_regs #(
    parameter int unsigned FIFO_SIZ = 16
)(
    input  logic           clk,
    input  logic           rst_n,
    uart_bus_if.sub        bus,
    output uart_pkg::bdr_t tx_bdr,
    output uart_pkg::bdr_t rx_bdr,
    output uart_pkg::bdr_t rx_smp,
    input  uart_pkg::cnt_t tx_cnt,
    input  uart_pkg::cnt_t rx_cnt,
    output logic           tx_push,
    output uart_pkg::dat_t tx_dat,
    output logic           rx_pop,
    input  uart_pkg::dat_t rx_dat,
    output logic           irq_tx,
    output logic           irq_rx
);

    // Qualified strobes
    logic           wr;
    logic           rd;
    // Interrupt limits
    uart_pkg::cnt_t tx_irq;
    uart_pkg::cnt_t rx_irq;
    logic           tx_full;

    assign wr = bus.trn & bus.wen;
    assign rd = bus.trn & bus.ren;

    //////////////////////////////
    // Configuration
    //////////////////////////////

    // New value visible the cycle after the write
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            tx_bdr <= '0;
            tx_irq <= '0;
            rx_bdr <= '0;
            rx_smp <= '0;
            rx_irq <= '0;
        end
        else if (wr)
        begin
            case (bus.adr)
                uart_pkg::REG_TX_BDR: tx_bdr <= uart_pkg::bdr_t'(bus.wdt);
                uart_pkg::REG_TX_IRQ: tx_irq <= uart_pkg::cnt_t'(bus.wdt);
                uart_pkg::REG_RX_BDR: rx_bdr <= uart_pkg::bdr_t'(bus.wdt);
                uart_pkg::REG_RX_SMP: rx_smp <= uart_pkg::bdr_t'(bus.wdt);
                uart_pkg::REG_RX_IRQ: rx_irq <= uart_pkg::cnt_t'(bus.wdt);
                default:
                begin
                end
            endcase
        end
    end

    //////////////////////////////
    // FIFO access
    //////////////////////////////

    // Writes to a full TX FIFO are dropped here already
    assign tx_full = (tx_cnt == uart_pkg::cnt_t'(FIFO_SIZ));
    assign tx_push = wr & (bus.adr == uart_pkg::REG_TX_DAT) & ~tx_full;
    assign tx_dat  = uart_pkg::dat_t'(bus.wdt);

    // Head is returned and popped in the same cycle
    assign rx_pop  = rd & (bus.adr == uart_pkg::REG_RX_DAT);

    // Read multiplexer, narrow fields zero extended
    always_comb
    begin
        case (bus.adr)
            uart_pkg::REG_TX_CNT: bus.rdt = uart_pkg::sys_t'(tx_cnt);
            uart_pkg::REG_TX_BDR: bus.rdt = uart_pkg::sys_t'(tx_bdr);
            uart_pkg::REG_TX_IRQ: bus.rdt = uart_pkg::sys_t'(tx_irq);
            uart_pkg::REG_RX_DAT: bus.rdt = uart_pkg::sys_t'(rx_dat);
            uart_pkg::REG_RX_CNT: bus.rdt = uart_pkg::sys_t'(rx_cnt);
            uart_pkg::REG_RX_BDR: bus.rdt = uart_pkg::sys_t'(rx_bdr);
            uart_pkg::REG_RX_SMP: bus.rdt = uart_pkg::sys_t'(rx_smp);
            uart_pkg::REG_RX_IRQ: bus.rdt = uart_pkg::sys_t'(rx_irq);
            // TX data register is write only
            default:              bus.rdt = '0;
        endcase
    end

    //////////////////////////////
    // Interrupts
    //////////////////////////////

    // TX wants more data
    assign irq_tx = (tx_cnt < tx_irq);
    // RX has data waiting
    assign irq_rx = (rx_cnt > rx_irq);

endmodule

// File: verilog/uart_periph.sv
//////////////////////////////
// UART peripheral top level
// Register bus, TX and RX FIFOs,
// transmitter and receiver
//////////////////////////////

`timescale 1ns/1ps

module uart_periph #(
    parameter int unsigned FIFO_SIZ = 16
)(
    input  logic           clk,
    input  logic           rst_n,
    // Register bus
    input  logic           bus_trn,
    input  logic           bus_wen,
    input  logic           bus_ren,
    input  uart_pkg::adr_t bus_adr,
    input  uart_pkg::sys_t bus_wdt,
    output uart_pkg::sys_t bus_rdt,
    // Serial line
    input  logic           uart_rxd,
    output logic           uart_txd,
    // Interrupts
    output logic           irq_tx,
    output logic           irq_rx
);

    // Configuration
    uart_pkg::bdr_t tx_bdr;
    uart_pkg::bdr_t rx_bdr;
    uart_pkg::bdr_t rx_smp;
    // TX FIFO
    logic           tx_push;
    uart_pkg::dat_t tx_wdat;
    logic           tx_pop;
    uart_pkg::dat_t tx_rdat;
    uart_pkg::cnt_t tx_cnt;
    // RX FIFO
    logic           rx_push;
    uart_pkg::dat_t rx_wdat;
    logic           rx_pop;
    uart_pkg::dat_t rx_rdat;
    uart_pkg::cnt_t rx_cnt;

    // Bus ports into the interface
    uart_bus_if bus ();

    assign bus.trn = bus_trn;
    assign bus.wen = bus_wen;
    assign bus.ren = bus_ren;
    assign bus.adr = bus_adr;
    assign bus.wdt = bus_wdt;
    assign bus_rdt = bus.rdt;

    uart_regs #(
        .FIFO_SIZ (FIFO_SIZ)
    ) regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus     (bus),
        .tx_bdr  (tx_bdr),
        .rx_bdr  (rx_bdr),
        .rx_smp  (rx_smp),
        .tx_cnt  (tx_cnt),
        .rx_cnt  (rx_cnt),
        .tx_push (tx_push),
        .tx_dat  (tx_wdat),
        .rx_pop  (rx_pop),
        .rx_dat  (rx_rdat),
        .irq_tx  (irq_tx),
        .irq_rx  (irq_rx)
    );

    // Bus to transmitter
    uart_fifo #(
        .FIFO_SIZ (FIFO_SIZ)
    ) tx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (tx_push),
        .wdat  (tx_wdat),
        .pop   (tx_pop),
        .rdat  (tx_rdat),
        .cnt   (tx_cnt)
    );

    // Receiver to bus
    uart_fifo #(
        .FIFO_SIZ (FIFO_SIZ)
    ) rx_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rx_push),
        .wdat  (rx_wdat),
        .pop   (rx_pop),
        .rdat  (rx_rdat),
        .cnt   (rx_cnt)
    );

    uart_tx tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .bdr      (tx_bdr),
        .fifo_cnt (tx_cnt),
        .fifo_dat (tx_rdat),
        .fifo_pop (tx_pop),
        .txd      (uart_txd)
    );

    uart_rx rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .rxd       (uart_rxd),
        .bdr       (rx_bdr),
        .smp       (rx_smp),
        .fifo_push (rx_push),
        .fifo_dat  (rx_wdat)
    );

endmodule

// File: bench/uart_periph_tb.sv
//////////////////////////////
// UART peripheral testbench
// Runs bus operations and serial frames from
// the pattern file, decodes uart_txd frames
// and compares against expected values
//////////////////////////////

`timescale 1ns/1ps

module uart_periph_tb;

    localparam int unsigned FIFO_SIZ = 16;
    localparam logic [31:0] SEED     = 32'hf9d924c1;

    logic           clk;
    logic           rst_n;
    logic           bus_trn;
    logic           bus_wen;
    logic           bus_ren;
    uart_pkg::adr_t bus_adr;
    uart_pkg::sys_t bus_wdt;
    uart_pkg::sys_t bus_rdt;
    logic           uart_rxd;
    logic           uart_txd;
    logic           irq_tx;
    logic           irq_rx;

    // Parsed pattern file with one entry per command
    string          ops[$];
    string          names[$];
    logic [31:0]    va[$];
    logic [31:0]    vb[$];

    // Bookkeeping
    string          test_name    = "none";
    int             test_errs    = 0;
    int             err_total    = 0;
    int             tests_run    = 0;
    int             tests_passed = 0;
    bit             in_test      = 0;
    longint         wd_limit     = 0;

    // Dividers as last written over the bus
    uart_pkg::bdr_t tx_div = '0;
    uart_pkg::bdr_t rx_div = '0;
    // Bytes decoded from uart_txd with the oldest first
    logic [7:0]     tx_seen[$];

    uart_periph #(
        .FIFO_SIZ (FIFO_SIZ)
    ) UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_trn  (bus_trn),
        .bus_wen  (bus_wen),
        .bus_ren  (bus_ren),
        .bus_adr  (bus_adr),
        .bus_wdt  (bus_wdt),
        .bus_rdt  (bus_rdt),
        .uart_rxd (uart_rxd),
        .uart_txd (uart_txd),
        .irq_tx   (irq_tx),
        .irq_rx   (irq_rx)
    );

    // 8 ns clock
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // Checks and bus access
    //////////////////////////////

    task automatic report_failure(input string msg);
        $display("%s in test %s", msg, test_name);
        test_errs++;
        err_total++;
    endtask

    task automatic compare(input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERR %s expected %0h actual %0h", test_name, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    // Random idle cycles between bus operations
    task automatic idle_gap;
        repeat ($urandom % 4) @(posedge clk);
    endtask

    task automatic bus_write(input uart_pkg::adr_t adr, input uart_pkg::sys_t dat);
        idle_gap();
        @(posedge clk);
        bus_trn <= 1'b1;
        bus_wen <= 1'b1;
        bus_adr <= adr;
        bus_wdt <= dat;
        @(posedge clk);
        bus_trn <= 1'b0;
        bus_wen <= 1'b0;
    endtask

    // Read data sampled mid cycle before the access ends at the next edge
    task automatic bus_read(input uart_pkg::adr_t adr, input uart_pkg::sys_t exp);
        uart_pkg::sys_t got;
        idle_gap();
        @(posedge clk);
        bus_trn <= 1'b1;
        bus_ren <= 1'b1;
        bus_adr <= adr;
        @(negedge clk);
        got = bus_rdt;
        @(posedge clk);
        bus_trn <= 1'b0;
        bus_ren <= 1'b0;
        compare(exp, got);
    endtask

    task automatic check_irq(input logic exp_tx, input logic exp_rx);
        @(negedge clk);
        compare(32'(exp_tx), 32'(irq_tx));
        compare(32'(exp_rx), 32'(irq_rx));
    endtask

    //////////////////////////////
    // Serial side
    //////////////////////////////

    // Called half a cycle into the start bit and samples near bit centers
    task automatic decode_tx_frame;
        int         per;
        int         i;
        logic [7:0] b;
        bit         good;
        per  = int'(tx_div) + 1;
        good = 1;
        repeat ((per - 1) / 2) @(negedge clk);
        if (uart_txd !== 1'b0)
        begin
            report_failure("Start bit on uart_txd ended before its center");
            good = 0;
        end
        for (i = 0; i < 8; i++)
        begin
            repeat (per) @(negedge clk);
            b[i] = uart_txd;
        end
        repeat (per) @(negedge clk);
        if (uart_txd !== 1'b1)
        begin
            report_failure("Stop bit on uart_txd was not high");
            good = 0;
        end
        if (good)
            tx_seen.push_back(b);
    endtask

    // Line monitor free running after reset
    initial
    begin
        @(posedge rst_n);
        forever
        begin
            @(negedge clk);
            if (uart_txd === 1'b0)
                decode_tx_frame();
        end
    end

    task automatic expect_tx_byte(input logic [7:0] exp);
        int waited;
        int limit;
        waited = 0;
        limit  = 20 * (int'(tx_div) + 1) + 100;
        while (tx_seen.size() == 0 && waited < limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (tx_seen.size() == 0)
            report_failure("No frame arrived on uart_txd in time");
        else
            compare(32'(exp), 32'(tx_seen.pop_front()));
    endtask

    // Start bit, 8 data bits LSB first and stop bit of one period each
    task automatic drive_rx_frame(input logic [7:0] dat, input logic stop);
        logic [9:0] frm;
        int         per;
        int         i;
        per = int'(rx_div) + 1;
        frm = {stop, dat, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            uart_rxd <= frm[i];
            repeat (per - 1) @(posedge clk);
        end
        @(posedge clk);
        uart_rxd <= 1'b1;
        // Idle line after a bad stop bit so the next start edge is seen
        if (!stop)
            repeat (per) @(posedge clk);
    endtask

    //////////////////////////////
    // Pattern handling
    //////////////////////////////

    task automatic load_patterns(output bit ok);
        int          fd;
        int          n;
        string       cmd;
        string       nm;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        bit          good;
        good = 1;
        fd   = $fopen("bench/uart_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open pattern file bench/uart_patterns.txt");
            good = 0;
        end
        else
        begin
            while (good && $fscanf(fd, "%s", cmd) == 1)
            begin
                a  = '0;
                b  = '0;
                nm = "";
                n  = 0;
                if (cmd.substr(0, 0) == "#")
                    n = $fgets(line, fd);
                else if (cmd == "test")
                    n = $fscanf(fd, "%s", nm);
                else if (cmd == "txframe")
                    n = $fscanf(fd, "%h", a);
                else if (cmd == "write" || cmd == "read" || cmd == "rxframe" ||
                         cmd == "irq" || cmd == "rxburst" || cmd == "rxdrain")
                begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2)
                        n = 0;
                end
                if (n <= 0)
                begin
                    $display("Pattern file has a bad line at command %s", cmd);
                    good = 0;
                end
                else if (cmd.substr(0, 0) != "#")
                begin
                    ops.push_back(cmd);
                    names.push_back(nm);
                    va.push_back(a);
                    vb.push_back(b);
                end
            end
            $fclose(fd);
        end
        ok = good;
    endtask

    // Frames times ten bit periods at the largest divider plus bus time
    task automatic set_watchdog_limit;
        longint frames;
        longint maxdiv;
        int     i;
        frames = 0;
        maxdiv = 0;
        for (i = 0; i < ops.size(); i++)
        begin
            if (ops[i] == "txframe" || ops[i] == "rxframe")
                frames++;
            else if (ops[i] == "rxburst")
                frames += longint'(va[i]);
            else if (ops[i] == "write" && (va[i][3:0] == uart_pkg::REG_TX_BDR ||
                     va[i][3:0] == uart_pkg::REG_RX_BDR) && longint'(vb[i][15:0]) > maxdiv)
                maxdiv = longint'(vb[i][15:0]);
        end
        wd_limit = frames * 10 * (maxdiv + 1) * 8 + longint'(ops.size()) * 80 + 2000;
    endtask

    task automatic finish_test;
        tests_run++;
        if (test_errs == 0)
        begin
            tests_passed++;
            $display("test %s passed", test_name);
        end
        else
            $display("test %s failed with %0d errors", test_name, test_errs);
    endtask

    task automatic run_patterns;
        int          i;
        int          j;
        logic [31:0] a;
        logic [31:0] b;
        logic [7:0]  val;
        for (i = 0; i < ops.size(); i++)
        begin
            a = va[i];
            b = vb[i];
            if (ops[i] == "test")
            begin
                if (in_test)
                    finish_test();
                test_name = names[i];
                test_errs = 0;
                in_test   = 1;
            end
            else if (ops[i] == "write")
            begin
                bus_write(a[3:0], b);
                if (a[3:0] == uart_pkg::REG_TX_BDR)
                    tx_div = b[15:0];
                if (a[3:0] == uart_pkg::REG_RX_BDR)
                    rx_div = b[15:0];
            end
            else if (ops[i] == "read")
                bus_read(a[3:0], b);
            else if (ops[i] == "txframe")
                expect_tx_byte(a[7:0]);
            else if (ops[i] == "rxframe")
                drive_rx_frame(a[7:0], b[0]);
            else if (ops[i] == "irq")
                check_irq(a[0], b[0]);
            else if (ops[i] == "rxburst")
            begin
                for (j = 0; j < int'(a); j++)
                begin
                    val = b[7:0] + 8'(j);
                    drive_rx_frame(val, 1'b1);
                end
            end
            else
            begin
                // Drain reads with an incrementing expected byte
                for (j = 0; j < int'(a); j++)
                begin
                    val = b[7:0] + 8'(j);
                    bus_read(uart_pkg::REG_RX_DAT, 32'(val));
                end
            end
        end
        if (in_test)
            finish_test();
    endtask

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////

    initial
    begin
        bit ok;
        rst_n    <= 1'b0;
        bus_trn  <= 1'b0;
        bus_wen  <= 1'b0;
        bus_ren  <= 1'b0;
        bus_adr  <= '0;
        bus_wdt  <= '0;
        uart_rxd <= 1'b1;
        void'($urandom(SEED));
        load_patterns(ok);
        if (ok)
        begin
            set_watchdog_limit();
            repeat (8) @(posedge clk);
            rst_n <= 1'b1;
            run_patterns();
        end
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_passed, tests_run - tests_passed, err_total);
        if (ok && err_total == 0 && tests_run > 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial
    begin
        wait (wd_limit != 0);
        #(wd_limit);
        $display("Run stopped by the watchdog after %0d ns in test %s", wd_limit, test_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/uart_patterns.txt
# Columns: command, then up to two hex values
# write adr dat | read adr exp | txframe byte | rxframe byte stop | irq tx rx | rxburst n first | rxdrain n first | test name
test reset_values
read 0 0
read 1 0
read 2 0
read 3 0
read 5 0
read 6 0
read 7 0
read 8 0
irq 0 0
test config_readback
write 2 3
write 6 7
write 7 3
write 3 2
write 8 1
read 2 3
read 6 7
read 7 3
read 3 2
read 8 1
irq 1 0
test tx_order
write 0 a5
write 0 3c
write 0 81
write 0 0f
read 1 3
irq 0 0
txframe a5
txframe 3c
txframe 81
txframe 0f
read 1 0
irq 1 0
test rx_order
rxframe 5a 1
rxframe 00 0
rxframe c3 1
read 5 2
irq 1 1
read 4 5a
read 5 1
irq 1 0
read 4 c3
read 5 0
test rx_overflow
rxburst 12 10
read 5 10
irq 1 1
rxdrain 10 10
read 5 0
irq 1 0

// File: build.f
verilog/uart_pkg.sv
verilog/uart_bus_if.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_periph.sv
bench/uart_periph_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the UART peripheral testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
    --top-module uart_periph_tb \
    --Mdir obj_dir -o uart_sim \
    -f build.f

./obj_dir/uart_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "UART testbench reported a failure"
    exit 1
fi

echo "UART testbench reported no failure"
exit 0
